/* mfb_splitter.f */
hdl/mfb_split_pkg.sv
hdl/mfb_frame_router.sv
hdl/mfb_output_demux.sv
hdl/mfb_splitter.sv
testbench/mfb_splitter_tb.sv

/* testbench/mfb_splitter_stimulus.txt */
# W data meta sof eof sof_pos eof_pos (rx meta holds user and select bits per region)
# E output data meta sof eof sof_pos eof_pos (meta holds user bits only), fields in hex
W 0123456789abcdef0123456789abcdef d71a1 1 1 0 07
E 1 0123456789abcdef0123456789abcdef 5ca1 1 1 0 07
W fedcba9876543210fedcba9876543210 88811 2 2 2 38
E 2 fedcba9876543210fedcba9876543210 2211 2 2 2 38
W 00112233445566778899aabbccddeeff 11333 3 3 0 33
E 3 00112233445566778899aabbccddeeff 4433 1 1 0 33
E 0 00112233445566778899aabbccddeeff 4433 2 2 0 33
W ffeeddccbbaa99887766554433221100 99955 1 0 0 00
E 1 ffeeddccbbaa99887766554433221100 6655 1 0 0 00
W 0f0e0d0c0b0a09080706050403020100 1e377 0 0 0 00
E 1 0f0e0d0c0b0a09080706050403020100 7877 0 0 0 00
W 101112131415161718191a1b1c1d1e1f e6a99 0 2 0 10
E 1 101112131415161718191a1b1c1d1e1f 9a99 0 2 0 10
W 202122232425262728292a2b2c2d2e2f ac4b0 2 0 0 00
E 2 202122232425262728292a2b2c2d2e2f b1b0 2 0 0 00
W 303132333435363738393a3b3c3d3e3f 704c0 1 1 1 02
E 2 303132333435363738393a3b3c3d3e3f c1c0 0 1 1 02
E 0 303132333435363738393a3b3c3d3e3f c1c0 1 0 1 02
W 404142434445464748494a4b4c4d4e4f 347d0 0 1 0 07
E 0 404142434445464748494a4b4c4d4e4f d1d0 0 1 0 07
W 505152535455565758595a5b5c5d5e5f 787e0 1 2 0 28
E 3 505152535455565758595a5b5c5d5e5f e1e0 1 2 0 28
W 606162636465666768696a6b6c6d6e6f 7c5f0 3 3 0 3b
E 1 606162636465666768696a6b6c6d6e6f f1f0 3 3 0 3b
W 707172737475767778797a7b7c7d7e7f 0060f 1 1 0 06
E 2 707172737475767778797a7b7c7d7e7f 010f 1 1 0 06

/* testbench/mfb_splitter_tb.sv */
////////////////////////////////////////
// Testbench for the MFB splitter at the default geometry.
// Input words and expected output words come from
// testbench/mfb_splitter_stimulus.txt, run from the project root.
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mfb_splitter_tb
    import mfb_split_pkg::*;
();

    localparam int OUTS      = DEF_SPLITTER_OUTPUTS;
    localparam int REGS      = DEF_REGIONS;
    localparam int DATA_W    = REGS*DEF_REGION_SIZE*DEF_BLOCK_SIZE*ITEM_WIDTH;
    localparam int META_W    = REGS*DEF_META_WIDTH;
    localparam int RXM_W     = REGS*(DEF_META_WIDTH + $clog2(OUTS));
    localparam int SOFP_W    = REGS*$clog2(DEF_REGION_SIZE);
    localparam int EOFP_W    = REGS*$clog2(DEF_REGION_SIZE*DEF_BLOCK_SIZE);
    localparam int MAX_WORDS = 64;

    logic              clk;
    logic              rst_n;
    logic [DATA_W-1:0] rx_data;
    logic [RXM_W-1:0]  rx_meta;
    logic [REGS-1:0]   rx_sof;
    logic [REGS-1:0]   rx_eof;
    logic [SOFP_W-1:0] rx_sof_pos;
    logic [EOFP_W-1:0] rx_eof_pos;
    logic              rx_src_rdy;
    logic              rx_dst_rdy;
    logic [DATA_W-1:0] tx_data    [OUTS-1:0];
    logic [META_W-1:0] tx_meta    [OUTS-1:0];
    logic [REGS-1:0]   tx_sof     [OUTS-1:0];
    logic [REGS-1:0]   tx_eof     [OUTS-1:0];
    logic [SOFP_W-1:0] tx_sof_pos [OUTS-1:0];
    logic [EOFP_W-1:0] tx_eof_pos [OUTS-1:0];
    logic              tx_src_rdy [OUTS-1:0];
    logic              tx_dst_rdy [OUTS-1:0];

    // input words in file order.
    logic [DATA_W-1:0] w_data [MAX_WORDS];
    logic [RXM_W-1:0]  w_meta [MAX_WORDS];
    logic [REGS-1:0]   w_sof  [MAX_WORDS];
    logic [REGS-1:0]   w_eof  [MAX_WORDS];
    logic [SOFP_W-1:0] w_sofp [MAX_WORDS];
    logic [EOFP_W-1:0] w_eofp [MAX_WORDS];

    // expected words, one ordered list per output.
    logic [DATA_W-1:0] exp_data [OUTS][MAX_WORDS];
    logic [META_W-1:0] exp_meta [OUTS][MAX_WORDS];
    logic [REGS-1:0]   exp_sof  [OUTS][MAX_WORDS];
    logic [REGS-1:0]   exp_eof  [OUTS][MAX_WORDS];
    logic [SOFP_W-1:0] exp_sofp [OUTS][MAX_WORDS];
    logic [EOFP_W-1:0] exp_eofp [OUTS][MAX_WORDS];

    int          exp_count [OUTS];
    int          rcv_count [OUTS];
    int          num_words;
    int          errors;
    logic        load_done;

    mfb_splitter #(
        .SPLITTER_OUTPUTS (DEF_SPLITTER_OUTPUTS),
        .REGIONS          (DEF_REGIONS),
        .REGION_SIZE      (DEF_REGION_SIZE),
        .BLOCK_SIZE       (DEF_BLOCK_SIZE),
        .META_WIDTH       (DEF_META_WIDTH)
    ) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_data    (rx_data),
        .rx_meta    (rx_meta),
        .rx_sof     (rx_sof),
        .rx_eof     (rx_eof),
        .rx_sof_pos (rx_sof_pos),
        .rx_eof_pos (rx_eof_pos),
        .rx_src_rdy (rx_src_rdy),
        .rx_dst_rdy (rx_dst_rdy),
        .tx_data    (tx_data),
        .tx_meta    (tx_meta),
        .tx_sof     (tx_sof),
        .tx_eof     (tx_eof),
        .tx_sof_pos (tx_sof_pos),
        .tx_eof_pos (tx_eof_pos),
        .tx_src_rdy (tx_src_rdy),
        .tx_dst_rdy (tx_dst_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic load_stimulus();
        int                fd;
        int                code;
        int                c;
        int                port;
        bit                reading;
        logic [7:0]        tag;
        logic [DATA_W-1:0] d;
        logic [RXM_W-1:0]  m_rx;
        logic [META_W-1:0] m_tx;
        logic [REGS-1:0]   s;
        logic [REGS-1:0]   e;
        logic [SOFP_W-1:0] sp;
        logic [EOFP_W-1:0] ep;

        fd = $fopen("testbench/mfb_splitter_stimulus.txt", "r");
        reading = (fd != 0);
        if (fd == 0) begin
            errors++;
            $display("could not open testbench/mfb_splitter_stimulus.txt");
        end
        while (reading) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                reading = 1'b0;
            end else if (tag == "#") begin
                c = 0;
                while (c != 10 && c != -1)
                    c = $fgetc(fd);
            end else if (tag == "W" && num_words < MAX_WORDS) begin
                code = $fscanf(fd, "%h %h %h %h %h %h", d, m_rx, s, e, sp, ep);
                w_data[num_words] = d;
                w_meta[num_words] = m_rx;
                w_sof[num_words]  = s;
                w_eof[num_words]  = e;
                w_sofp[num_words] = sp;
                w_eofp[num_words] = ep;
                num_words++;
            end else if (tag == "E") begin
                code = $fscanf(fd, "%d %h %h %h %h %h %h", port, d, m_tx, s, e, sp, ep);
                if (port >= 0 && port < OUTS && exp_count[port] < MAX_WORDS) begin
                    exp_data[port][exp_count[port]] = d;
                    exp_meta[port][exp_count[port]] = m_tx;
                    exp_sof[port][exp_count[port]]  = s;
                    exp_eof[port][exp_count[port]]  = e;
                    exp_sofp[port][exp_count[port]] = sp;
                    exp_eofp[port][exp_count[port]] = ep;
                    exp_count[port]++;
                end
            end else begin
                errors++;
                reading = 1'b0;
                $display("the stimulus file has a line that cannot be read, tag %c", tag);
            end
        end
        if (fd != 0)
            $fclose(fd);
    endtask

    // holds the word on the bus until the DUT takes it.
    task automatic send_word(input int i);
        rx_data    <= w_data[i];
        rx_meta    <= w_meta[i];
        rx_sof     <= w_sof[i];
        rx_eof     <= w_eof[i];
        rx_sof_pos <= w_sofp[i];
        rx_eof_pos <= w_eofp[i];
        rx_src_rdy <= 1'b1;
        @(posedge clk);
        while (!rx_dst_rdy)
            @(posedge clk);
    endtask

    task automatic check_outputs_idle();
        for (int o = 0; o < OUTS; o++) begin
            assert (tx_src_rdy[o] === 1'b0) else begin
                errors++;
                $display("[FAIL] %0t ns: output %0d has tx_src_rdy high before any input",
                         $time, o);
            end
        end
    endtask

    task automatic check_output(input int o);
        int k;

        k = rcv_count[o];
        assert (k < exp_count[o]) else begin
            errors++;
            $display("output %0d delivered more than its %0d expected words, at %0t ns",
                     o, exp_count[o], $time);
        end
        if (k < exp_count[o]) begin
            assert (tx_data[o] === exp_data[o][k] && tx_meta[o] === exp_meta[o][k] &&
                    tx_sof[o] === exp_sof[o][k] && tx_eof[o] === exp_eof[o][k] &&
                    tx_sof_pos[o] === exp_sofp[o][k] && tx_eof_pos[o] === exp_eofp[o][k])
            else begin
                errors++;
                $display("[FAIL] %0t ns: output %0d word %0d got %h %h sof %b eof %b pos %b %h",
                         $time, o, k, tx_data[o], tx_meta[o], tx_sof[o], tx_eof[o],
                         tx_sof_pos[o], tx_eof_pos[o]);
                $display("       expected %h %h sof %b eof %b pos %b %h", exp_data[o][k],
                         exp_meta[o][k], exp_sof[o][k], exp_eof[o][k], exp_sofp[o][k],
                         exp_eofp[o][k]);
            end
        end
        rcv_count[o] = k + 1;
    endtask

    function automatic bit all_received();
        bit done;

        done = 1'b1;
        for (int o = 0; o < OUTS; o++) begin
            if (rcv_count[o] < exp_count[o])
                done = 1'b0;
        end
        return done;
    endfunction

    // random back-pressure, ready about two cycles in three.
    initial begin
        void'($urandom(32'he3ed71a1));
        forever begin
            @(posedge clk);
            for (int o = 0; o < OUTS; o++) begin
                if (!rst_n)
                    tx_dst_rdy[o] <= 1'b0;
                else
                    tx_dst_rdy[o] <= ($urandom % 3) != 0;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            for (int o = 0; o < OUTS; o++) begin
                if (tx_src_rdy[o] && tx_dst_rdy[o])
                    check_output(o);
            end
        end
    end

    initial begin
        wait (load_done);
        repeat (200*num_words + 100) @(posedge clk); // margin covers reset and drain.
        $display("timeout: the run did not finish within %0d cycles", 200*num_words + 100);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        rx_data    = '0;
        rx_meta    = '0;
        rx_sof     = '0;
        rx_eof     = '0;
        rx_sof_pos = '0;
        rx_eof_pos = '0;
        rx_src_rdy = 1'b0;
        for (int o = 0; o < OUTS; o++) begin
            tx_dst_rdy[o] = 1'b0;
            exp_count[o]  = 0;
            rcv_count[o]  = 0;
        end
        errors    = 0;
        num_words = 0;
        load_done = 1'b0;

        load_stimulus();
        load_done = 1'b1;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_outputs_idle();

        @(posedge clk);
        for (int i = 0; i < num_words; i++)
            send_word(i);
        rx_src_rdy <= 1'b0;

        while (!all_received())
            @(posedge clk);
        repeat (20) @(posedge clk); // late extra words would still show up here.

        for (int o = 0; o < OUTS; o++) begin
            assert (rcv_count[o] == exp_count[o]) else begin
                errors++;
                $display("output %0d delivered %0d words instead of %0d",
                         o, rcv_count[o], exp_count[o]);
            end
        end

        $write("summary: %0d errors, words received per output:", errors);
        for (int o = 0; o < OUTS; o++)
            $write(" %0d", rcv_count[o]);
        $write("\n");
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/mfb_splitter.sv */
////////////////////////////////////////
// MFB frame splitter, latency of one clock.
// rx_meta per region holds user bits low and
// the select field above them.
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mfb_splitter
    import mfb_split_pkg::*;
#(
    parameter int SPLITTER_OUTPUTS = DEF_SPLITTER_OUTPUTS,
    parameter int REGIONS          = DEF_REGIONS,
    parameter int REGION_SIZE      = DEF_REGION_SIZE,
    parameter int BLOCK_SIZE       = DEF_BLOCK_SIZE,
    parameter int META_WIDTH       = DEF_META_WIDTH,
    localparam int SEL_WIDTH       = $clog2(SPLITTER_OUTPUTS),
    localparam int DATA_W          = REGIONS*REGION_SIZE*BLOCK_SIZE*ITEM_WIDTH,
    localparam int META_W          = REGIONS*META_WIDTH,
    localparam int RX_META_W       = REGIONS*(META_WIDTH + SEL_WIDTH),
    localparam int SOF_POS_W       = REGIONS*$clog2(REGION_SIZE),
    localparam int EOF_POS_W       = REGIONS*$clog2(REGION_SIZE*BLOCK_SIZE)
) (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic [DATA_W-1:0]    rx_data,
    input  logic [RX_META_W-1:0] rx_meta,
    input  logic [REGIONS-1:0]   rx_sof,
    input  logic [REGIONS-1:0]   rx_eof,
    input  logic [SOF_POS_W-1:0] rx_sof_pos,
    input  logic [EOF_POS_W-1:0] rx_eof_pos,
    input  logic                 rx_src_rdy,
    output logic                 rx_dst_rdy,

    output logic [DATA_W-1:0]    tx_data    [SPLITTER_OUTPUTS-1:0],
    output logic [META_W-1:0]    tx_meta    [SPLITTER_OUTPUTS-1:0],
    output logic [REGIONS-1:0]   tx_sof     [SPLITTER_OUTPUTS-1:0],
    output logic [REGIONS-1:0]   tx_eof     [SPLITTER_OUTPUTS-1:0],
    output logic [SOF_POS_W-1:0] tx_sof_pos [SPLITTER_OUTPUTS-1:0],
    output logic [EOF_POS_W-1:0] tx_eof_pos [SPLITTER_OUTPUTS-1:0],
    output logic                 tx_src_rdy [SPLITTER_OUTPUTS-1:0],
    input  logic                 tx_dst_rdy [SPLITTER_OUTPUTS-1:0]
);

    localparam int SLOT_W = META_WIDTH + SEL_WIDTH; // metadata bits per region.

    logic [META_W-1:0]            rx_meta_user;
    logic [REGIONS*SEL_WIDTH-1:0] rx_sel;
    logic [REGIONS-1:0]           region_hit     [SPLITTER_OUTPUTS-1:0];
    logic [REGIONS-1:0]           region_sof_hit [SPLITTER_OUTPUTS-1:0];
    logic [REGIONS-1:0]           region_eof_hit [SPLITTER_OUTPUTS-1:0];
    logic                         accept;

    for (genvar r = 0; r < REGIONS; r++) begin : g_meta
        assign rx_meta_user[r*META_WIDTH +: META_WIDTH] = rx_meta[r*SLOT_W +: META_WIDTH];
        assign rx_sel[r*SEL_WIDTH +: SEL_WIDTH] = rx_meta[r*SLOT_W + META_WIDTH +: SEL_WIDTH];
    end

    mfb_frame_router #(
        .SPLITTER_OUTPUTS (SPLITTER_OUTPUTS),
        .REGIONS          (REGIONS),
        .REGION_SIZE      (REGION_SIZE),
        .BLOCK_SIZE       (BLOCK_SIZE)
    ) u_router (
        .clk              (clk),
        .rst_n            (rst_n),
        .rx_sof           (rx_sof),
        .rx_eof           (rx_eof),
        .rx_sof_pos       (rx_sof_pos),
        .rx_eof_pos       (rx_eof_pos),
        .rx_sel           (rx_sel),
        .rx_src_rdy       (rx_src_rdy),
        .accept           (accept),
        .region_hit       (region_hit),
        .region_sof_hit   (region_sof_hit),
        .region_eof_hit   (region_eof_hit),
        .next_state       ()
    );

    mfb_output_demux #(
        .SPLITTER_OUTPUTS (SPLITTER_OUTPUTS),
        .REGIONS          (REGIONS),
        .REGION_SIZE      (REGION_SIZE),
        .BLOCK_SIZE       (BLOCK_SIZE),
        .META_WIDTH       (META_WIDTH)
    ) u_demux (
        .clk              (clk),
        .rst_n            (rst_n),
        .rx_data          (rx_data),
        .rx_meta_user     (rx_meta_user),
        .rx_sof_pos       (rx_sof_pos),
        .rx_eof_pos       (rx_eof_pos),
        .rx_src_rdy       (rx_src_rdy),
        .rx_dst_rdy       (rx_dst_rdy),
        .accept           (accept),
        .region_hit       (region_hit),
        .region_sof_hit   (region_sof_hit),
        .region_eof_hit   (region_eof_hit),
        .tx_data          (tx_data),
        .tx_meta          (tx_meta),
        .tx_sof           (tx_sof),
        .tx_eof           (tx_eof),
        .tx_sof_pos       (tx_sof_pos),
        .tx_eof_pos       (tx_eof_pos),
        .tx_src_rdy       (tx_src_rdy),
        .tx_dst_rdy       (tx_dst_rdy)
    );

endmodule

`default_nettype wire

/* hdl/mfb_output_demux.sv */
////////////////////////////////////////
// One register stage per output.
// A word needing several outputs waits until all of them can take it.
// Words with no frame content are accepted and dropped.
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mfb_output_demux
    import mfb_split_pkg::*;
#(
    parameter int SPLITTER_OUTPUTS = DEF_SPLITTER_OUTPUTS,
    parameter int REGIONS          = DEF_REGIONS,
    parameter int REGION_SIZE      = DEF_REGION_SIZE,
    parameter int BLOCK_SIZE       = DEF_BLOCK_SIZE,
    parameter int META_WIDTH       = DEF_META_WIDTH,
    localparam int DATA_W          = REGIONS*REGION_SIZE*BLOCK_SIZE*ITEM_WIDTH,
    localparam int META_W          = REGIONS*META_WIDTH,
    localparam int SOF_POS_W       = REGIONS*$clog2(REGION_SIZE),
    localparam int EOF_POS_W       = REGIONS*$clog2(REGION_SIZE*BLOCK_SIZE)
) (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic [DATA_W-1:0]    rx_data,
    input  logic [META_W-1:0]    rx_meta_user,
    input  logic [SOF_POS_W-1:0] rx_sof_pos,
    input  logic [EOF_POS_W-1:0] rx_eof_pos,
    input  logic                 rx_src_rdy,
    output logic                 rx_dst_rdy,
    output logic                 accept,

    input  logic [REGIONS-1:0]   region_hit     [SPLITTER_OUTPUTS-1:0],
    input  logic [REGIONS-1:0]   region_sof_hit [SPLITTER_OUTPUTS-1:0],
    input  logic [REGIONS-1:0]   region_eof_hit [SPLITTER_OUTPUTS-1:0],

    output logic [DATA_W-1:0]    tx_data    [SPLITTER_OUTPUTS-1:0],
    output logic [META_W-1:0]    tx_meta    [SPLITTER_OUTPUTS-1:0],
    output logic [REGIONS-1:0]   tx_sof     [SPLITTER_OUTPUTS-1:0],
    output logic [REGIONS-1:0]   tx_eof     [SPLITTER_OUTPUTS-1:0],
    output logic [SOF_POS_W-1:0] tx_sof_pos [SPLITTER_OUTPUTS-1:0],
    output logic [EOF_POS_W-1:0] tx_eof_pos [SPLITTER_OUTPUTS-1:0],
    output logic                 tx_src_rdy [SPLITTER_OUTPUTS-1:0],
    input  logic                 tx_dst_rdy [SPLITTER_OUTPUTS-1:0]
);

    logic [SPLITTER_OUTPUTS-1:0] target;     // outputs the current word needs.
    logic [SPLITTER_OUTPUTS-1:0] stage_free; // stage is empty or draining now.

    always_comb begin
        for (int o = 0; o < SPLITTER_OUTPUTS; o++) begin
            target[o]     = |region_hit[o];
            stage_free[o] = !tx_src_rdy[o] || tx_dst_rdy[o];
        end
    end

    // outputs the word does not touch never hold it back.
    assign rx_dst_rdy = &(stage_free | ~target);
    assign accept     = rx_src_rdy && rx_dst_rdy;

    for (genvar o = 0; o < SPLITTER_OUTPUTS; o++) begin : g_stage
        logic load;

        assign load = accept && target[o];

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                tx_src_rdy[o] <= 1'b0;
            end else if (load) begin
                tx_src_rdy[o] <= 1'b1;
            end else if (tx_dst_rdy[o]) begin
                tx_src_rdy[o] <= 1'b0; // word left and nothing replaces it.
            end
        end

        // a shared region reaches both outputs, each keeping only its own flags.
        always_ff @(posedge clk) begin
            if (load) begin
                tx_data[o]    <= rx_data;
                tx_meta[o]    <= rx_meta_user;
                tx_sof[o]     <= region_sof_hit[o];
                tx_eof[o]     <= region_eof_hit[o];
                tx_sof_pos[o] <= rx_sof_pos;
                tx_eof_pos[o] <= rx_eof_pos;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/mfb_frame_router.sv */
////////////////////////////////////////
// Per-region output assignment for MFB frames.
// At most one frame may start in a region.
// Hit masks are zero while rx_src_rdy is low.
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mfb_frame_router
    import mfb_split_pkg::*;
#(
    parameter int SPLITTER_OUTPUTS = DEF_SPLITTER_OUTPUTS,
    parameter int REGIONS          = DEF_REGIONS,
    parameter int REGION_SIZE      = DEF_REGION_SIZE,
    parameter int BLOCK_SIZE       = DEF_BLOCK_SIZE,
    localparam int SEL_WIDTH       = $clog2(SPLITTER_OUTPUTS),
    localparam int SOF_POS_W       = $clog2(REGION_SIZE),
    localparam int EOF_POS_W       = $clog2(REGION_SIZE*BLOCK_SIZE)
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [REGIONS-1:0]           rx_sof,
    input  logic [REGIONS-1:0]           rx_eof,
    input  logic [REGIONS*SOF_POS_W-1:0] rx_sof_pos,
    input  logic [REGIONS*EOF_POS_W-1:0] rx_eof_pos,
    input  logic [REGIONS*SEL_WIDTH-1:0] rx_sel,
    input  logic                         rx_src_rdy,
    input  logic                         accept,
    output logic [REGIONS-1:0]           region_hit     [SPLITTER_OUTPUTS-1:0],
    output logic [REGIONS-1:0]           region_sof_hit [SPLITTER_OUTPUTS-1:0],
    output logic [REGIONS-1:0]           region_eof_hit [SPLITTER_OUTPUTS-1:0],
    output frame_state_t                 next_state
);

    frame_state_t         state;
    logic [SEL_WIDTH-1:0] cur_sel;  // output of the frame still open.
    logic [SEL_WIDTH-1:0] next_sel;

    always_comb begin
        logic                 in_frame;
        logic [SEL_WIDTH-1:0] sel;
        logic [SEL_WIDTH-1:0] new_sel;
        logic [EOF_POS_W-1:0] sof_item;
        logic [EOF_POS_W-1:0] eof_item;
        logic                 eof_old;

        for (int o = 0; o < SPLITTER_OUTPUTS; o++) begin
            region_hit[o]     = '0;
            region_sof_hit[o] = '0;
            region_eof_hit[o] = '0;
        end
        in_frame = (state == IN_FRAME);
        sel      = cur_sel;
        new_sel  = '0;
        sof_item = '0;
        eof_item = '0;
        eof_old  = 1'b0;

        if (rx_src_rdy) begin
            // regions are walked from low to high, the order of items on the bus.
            for (int r = 0; r < REGIONS; r++) begin
                new_sel  = rx_sel[r*SEL_WIDTH +: SEL_WIDTH];
                sof_item = EOF_POS_W'(rx_sof_pos[r*SOF_POS_W +: SOF_POS_W] * BLOCK_SIZE);
                eof_item = rx_eof_pos[r*EOF_POS_W +: EOF_POS_W];
                // an EOF placed before the SOF closes the frame already open.
                eof_old  = rx_eof[r] && (!rx_sof[r] || (eof_item < sof_item));

                if (in_frame) begin
                    region_hit[sel][r] = 1'b1;
                    if (eof_old) begin
                        region_eof_hit[sel][r] = 1'b1;
                        in_frame               = 1'b0;
                    end
                end

                if (rx_sof[r]) begin
                    sel                    = new_sel; // select is only sampled at SOF.
                    region_hit[sel][r]     = 1'b1;
                    region_sof_hit[sel][r] = 1'b1;
                    in_frame               = 1'b1;
                    if (rx_eof[r] && !eof_old) begin
                        // the new frame fits inside this region.
                        region_eof_hit[sel][r] = 1'b1;
                        in_frame               = 1'b0;
                    end
                end
            end
        end

        next_state = in_frame ? IN_FRAME : IDLE;
        next_sel   = sel;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            cur_sel <= '0;
        end else if (accept) begin
            state   <= next_state;
            cur_sel <= next_sel;
        end
    end

endmodule

`default_nettype wire

/* hdl/mfb_split_pkg.sv */
////////////////////////////////////////
// Default MFB geometry for the splitter.
// Items are always 8 bits wide.
////////////////////////////////////////

`default_nettype none

package mfb_split_pkg;

    localparam int DEF_SPLITTER_OUTPUTS = 4;
    localparam int DEF_REGIONS          = 2;
    localparam int DEF_REGION_SIZE      = 2; // blocks per region.
    localparam int DEF_BLOCK_SIZE       = 4; // items per block.
    localparam int DEF_META_WIDTH       = 8; // user bits per region.

    localparam int ITEM_WIDTH = 8;

    // the router is either between frames or inside one that carries on
    // into the next word.
    typedef enum logic {
        IDLE,
        IN_FRAME
    } frame_state_t;

endpackage

`default_nettype wire
